/* design/uoramPkg.sv */
package uoramPkg;

    // backend command encoding
    typedef enum logic [1:0] {
        Update  = 2'd0,
        Append  = 2'd1,
        Read    = 2'd2,
        ReadRmv = 2'd3
    } beCmdT;

    // which path the data path is steering for the current access
    typedef enum logic [1:0] {
        Idle       = 2'd0,
        ProgStore  = 2'd1,
        DataReturn = 2'd2,
        PosMap     = 2'd3
    } flowModeT;

    localparam int QDepthWidth = 4;

    // index width, never below one bit
    function automatic int unsigned idxWidth(input int unsigned n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

    // chunks that make up one leaf word
    function automatic int unsigned chunksPerLeaf(input int unsigned leafWidth,
                                                  input int unsigned fedWidth);
        return leafWidth / fedWidth;
    endfunction

endpackage

/* design/routeCtrlIf.sv */
`timescale 1ns/1ns

interface routeCtrlIf;
    import uoramPkg::*;

    flowModeT mode;
    // one chunk of the counted stream transferred this cycle
    logic     chunkMoved;
    logic     blockLast;
    // store buffer and evict funnel both drained
    logic     storeIdle;

    modport sequencer (
        output mode,
        output blockLast,
        input  chunkMoved,
        input  storeIdle
    );

    modport router (
        input  mode,
        input  blockLast,
        output chunkMoved,
        output storeIdle
    );

endinterface

/* design/storeBuffer.sv */
`timescale 1ns/1ns

module storeBuffer #(
    parameter int Width = 32,
    parameter int Depth = 8
) (
    input  logic             Clock,
    input  logic             rst,
    input  logic             inValid,
    output logic             inReady,
    input  logic [Width-1:0] inData,
    output logic             outValid,
    input  logic             outReady,
    output logic [Width-1:0] outData,
    output logic             empty
);
    import uoramPkg::*;

    localparam int PtrWidth = idxWidth(Depth);
    localparam int CntWidth = idxWidth(Depth + 1);

    logic [Width-1:0]    mem [Depth];
    logic [PtrWidth-1:0] wrPtr;
    logic [PtrWidth-1:0] rdPtr;
    logic [CntWidth-1:0] count;
    logic                doWrite;
    logic                doRead;

    assign inReady  = (count != CntWidth'(Depth));
    assign outValid = (count != '0);
    assign empty    = (count == '0);
    // head entry shows without a read cycle
    assign outData  = mem[rdPtr];

    assign doWrite = inValid && inReady;
    assign doRead  = outValid && outReady;

    always_ff @(posedge Clock) begin
        if (doWrite) begin
            mem[wrPtr] <= inData;
        end
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite) begin
                wrPtr <= (wrPtr == PtrWidth'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= (rdPtr == PtrWidth'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            if (doWrite && !doRead) begin
                count <= count + 1'b1;
            end else if (doRead && !doWrite) begin
                count <= count - 1'b1;
            end
        end
    end

    // a write never lands on an occupied slot
    assert property (@(posedge Clock) disable iff (rst)
        doWrite |-> (wrPtr != rdPtr || count == '0));

endmodule

/* design/refillFunnel.sv */
`timescale 1ns/1ns

module refillFunnel #(
    parameter int FedWidth  = 32,
    parameter int LeafWidth = 64
) (
    input  logic                 Clock,
    input  logic                 rst,
    input  logic                 inValid,
    output logic                 inReady,
    input  logic [FedWidth-1:0]  inData,
    output logic                 outValid,
    input  logic                 outReady,
    output logic [LeafWidth-1:0] outData
);
    import uoramPkg::*;

    localparam int Ratio     = chunksPerLeaf(LeafWidth, FedWidth);
    localparam int SlotWidth = idxWidth(Ratio);

    logic [LeafWidth-1:0] word;
    logic [SlotWidth-1:0] slot;
    logic                 full;
    logic                 take;

    // no new chunks while the assembled word waits
    assign inReady  = !full;
    assign outValid = full;
    assign outData  = word;
    assign take     = inValid && inReady;

    // lowest chunk lands in the lowest slot
    always_ff @(posedge Clock) begin
        if (take) begin
            word[slot*FedWidth +: FedWidth] <= inData;
        end
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            slot <= '0;
            full <= 1'b0;
        end else if (take) begin
            if (slot == SlotWidth'(Ratio - 1)) begin
                slot <= '0;
                full <= 1'b1;
            end else begin
                slot <= slot + 1'b1;
            end
        end else if (full && outReady) begin
            full <= 1'b0;
        end
    end

endmodule

/* design/evictFunnel.sv */
`timescale 1ns/1ns

module evictFunnel #(
    parameter int FedWidth  = 32,
    parameter int LeafWidth = 64
) (
    input  logic                 Clock,
    input  logic                 rst,
    input  logic                 inValid,
    output logic                 inReady,
    input  logic [LeafWidth-1:0] inData,
    output logic                 outValid,
    input  logic                 outReady,
    output logic [FedWidth-1:0]  outData,
    output logic                 empty
);
    import uoramPkg::*;

    localparam int Ratio     = chunksPerLeaf(LeafWidth, FedWidth);
    localparam int SlotWidth = idxWidth(Ratio);

    logic [LeafWidth-1:0] word;
    logic [SlotWidth-1:0] slot;
    logic                 busy;

    // next word only after the last chunk has gone out
    assign inReady  = !busy;
    assign outValid = busy;
    assign empty    = !busy;
    assign outData  = word[slot*FedWidth +: FedWidth];

    always_ff @(posedge Clock) begin
        if (inValid && inReady) begin
            word <= inData;
        end
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            busy <= 1'b0;
            slot <= '0;
        end else if (inValid && inReady) begin
            busy <= 1'b1;
            slot <= '0;
        end else if (outValid && outReady) begin
            if (slot == SlotWidth'(Ratio - 1)) begin
                busy <= 1'b0;
                slot <= '0;
            end else begin
                slot <= slot + 1'b1;
            end
        end
    end

endmodule

/* design/chunkRouter.sv */
`timescale 1ns/1ns

module chunkRouter #(
    parameter int FedWidth    = 32,
    parameter int LeafWidth   = 64,
    parameter int BlockChunks = 8
) (
    input  logic                 Clock,
    input  logic                 rst,
    routeCtrlIf.router           ctrl,
    // network in
    input  logic                 dataInValid,
    output logic                 dataInReady,
    input  logic [FedWidth-1:0]  dataIn,
    // network return
    output logic                 returnDataValid,
    input  logic                 returnDataReady,
    output logic [FedWidth-1:0]  returnData,
    // PLB evict
    input  logic                 evictDataValid,
    output logic                 evictDataReady,
    input  logic [LeafWidth-1:0] evictData,
    // PLB refill
    output logic                 refillDataValid,
    input  logic                 refillDataReady,
    output logic [LeafWidth-1:0] refillData,
    // backend store
    output logic                 storeDataValid,
    input  logic                 storeDataReady,
    output logic [FedWidth-1:0]  storeData,
    // backend load
    input  logic                 loadDataValid,
    output logic                 loadDataReady,
    input  logic [FedWidth-1:0]  loadData
);
    import uoramPkg::*;

    logic                progStore;
    logic                dataReturn;
    logic                posMap;
    logic                bufValid;
    logic                bufReady;
    logic [FedWidth-1:0] bufData;
    logic                bufEmpty;
    logic                evChunkValid;
    logic                evChunkReady;
    logic [FedWidth-1:0] evChunk;
    logic                evEmpty;
    logic                rfReady;

    assign progStore  = (ctrl.mode == ProgStore);
    assign dataReturn = (ctrl.mode == DataReturn);
    assign posMap     = (ctrl.mode == PosMap);

    // store side: network during program store, evicted PLB words otherwise
    assign bufValid     = progStore ? dataInValid : evChunkValid;
    assign bufData      = progStore ? dataIn : evChunk;
    assign dataInReady  = progStore && bufReady;
    assign evChunkReady = !progStore && bufReady;

    // load side
    assign returnDataValid = dataReturn && loadDataValid;
    assign returnData      = loadData;
    assign loadDataReady   = dataReturn ? returnDataReady : (posMap && rfReady);

    always_comb begin
        case (ctrl.mode)
            ProgStore:  ctrl.chunkMoved = dataInValid && dataInReady;
            DataReturn: ctrl.chunkMoved = returnDataValid && returnDataReady;
            PosMap:     ctrl.chunkMoved = loadDataValid && loadDataReady;
            default:    ctrl.chunkMoved = 1'b0;
        endcase
    end

    assign ctrl.storeIdle = bufEmpty && evEmpty;

    storeBuffer #(
        .Width (FedWidth),
        .Depth (BlockChunks)
    ) storeBuf (
        .Clock    (Clock),
        .rst      (rst),
        .inValid  (bufValid),
        .inReady  (bufReady),
        .inData   (bufData),
        .outValid (storeDataValid),
        .outReady (storeDataReady),
        .outData  (storeData),
        .empty    (bufEmpty)
    );

    refillFunnel #(
        .FedWidth  (FedWidth),
        .LeafWidth (LeafWidth)
    ) refill (
        .Clock    (Clock),
        .rst      (rst),
        .inValid  (posMap && loadDataValid),
        .inReady  (rfReady),
        .inData   (loadData),
        .outValid (refillDataValid),
        .outReady (refillDataReady),
        .outData  (refillData)
    );

    evictFunnel #(
        .FedWidth  (FedWidth),
        .LeafWidth (LeafWidth)
    ) evict (
        .Clock    (Clock),
        .rst      (rst),
        .inValid  (evictDataValid),
        .inReady  (evictDataReady),
        .inData   (evictData),
        .outValid (evChunkValid),
        .outReady (evChunkReady),
        .outData  (evChunk),
        .empty    (evEmpty)
    );

    // last chunk of a posmap block completes a refill word
    assert property (@(posedge Clock) disable iff (rst)
        (posMap && ctrl.chunkMoved && ctrl.blockLast) |=> refillDataValid);

endmodule

/* design/accessSequencer.sv */
`timescale 1ns/1ns

module accessSequencer #(
    parameter int BlockChunks = 8
) (
    input  logic                             Clock,
    input  logic                             rst,
    input  logic                             cmdValid,
    output logic                             cmdReady,
    input  uoramPkg::beCmdT                  cmd,
    input  logic [uoramPkg::QDepthWidth-1:0] qDepth,
    routeCtrlIf.sequencer                    ctrl
);
    import uoramPkg::*;

    localparam int CntWidth = idxWidth(BlockChunks);

    logic [CntWidth-1:0] chunkCnt;
    flowModeT            nextMode;

    // queued requests go to the position map first
    always_comb begin
        if (qDepth != '0) begin
            nextMode = PosMap;
        end else if (cmd == Read || cmd == ReadRmv) begin
            nextMode = DataReturn;
        end else begin
            nextMode = ProgStore;
        end
    end

    // new access only once the store side has drained
    assign cmdReady = (ctrl.mode == Idle) && ctrl.storeIdle;

    assign ctrl.blockLast = (chunkCnt == CntWidth'(BlockChunks - 1));

    always_ff @(posedge Clock) begin
        if (rst) begin
            ctrl.mode <= Idle;
            chunkCnt  <= '0;
        end else if (cmdValid && cmdReady) begin
            ctrl.mode <= nextMode;
            chunkCnt  <= '0;
        end else if (ctrl.chunkMoved) begin
            if (ctrl.blockLast) begin
                // block complete, back to idle
                ctrl.mode <= Idle;
                chunkCnt  <= '0;
            end else begin
                chunkCnt <= chunkCnt + 1'b1;
            end
        end
    end

    // a flow runs to completion before another one starts
    assert property (@(posedge Clock) disable iff (rst)
        (ctrl.mode != Idle) |=> (ctrl.mode == $past(ctrl.mode) || ctrl.mode == Idle));

    // router counts chunks only inside a flow
    assert property (@(posedge Clock) disable iff (rst)
        (ctrl.mode == Idle) |-> !ctrl.chunkMoved);

endmodule

/* design/uoramDataPath.sv */
`timescale 1ns/1ns

module uoramDataPath #(
    parameter int FedWidth    = 32,
    parameter int LeafWidth   = 64,
    parameter int BlockChunks = 8
) (
    input  logic                             Clock,
    input  logic                             rst,
    // host command
    input  logic                             cmdValid,
    output logic                             cmdReady,
    input  uoramPkg::beCmdT                  cmd,
    input  logic [uoramPkg::QDepthWidth-1:0] qDepth,
    // network in
    input  logic                             dataInValid,
    output logic                             dataInReady,
    input  logic [FedWidth-1:0]              dataIn,
    // network return
    output logic                             returnDataValid,
    input  logic                             returnDataReady,
    output logic [FedWidth-1:0]              returnData,
    // PLB evict
    input  logic                             evictDataValid,
    output logic                             evictDataReady,
    input  logic [LeafWidth-1:0]             evictData,
    // PLB refill
    output logic                             refillDataValid,
    input  logic                             refillDataReady,
    output logic [LeafWidth-1:0]             refillData,
    // backend store
    output logic                             storeDataValid,
    input  logic                             storeDataReady,
    output logic [FedWidth-1:0]              storeData,
    // backend load
    input  logic                             loadDataValid,
    output logic                             loadDataReady,
    input  logic [FedWidth-1:0]              loadData
);

    routeCtrlIf ctrlBus ();

    accessSequencer #(
        .BlockChunks (BlockChunks)
    ) sequencer (
        .Clock    (Clock),
        .rst      (rst),
        .cmdValid (cmdValid),
        .cmdReady (cmdReady),
        .cmd      (cmd),
        .qDepth   (qDepth),
        .ctrl     (ctrlBus.sequencer)
    );

    chunkRouter #(
        .FedWidth    (FedWidth),
        .LeafWidth   (LeafWidth),
        .BlockChunks (BlockChunks)
    ) router (
        .Clock           (Clock),
        .rst             (rst),
        .ctrl            (ctrlBus.router),
        .dataInValid     (dataInValid),
        .dataInReady     (dataInReady),
        .dataIn          (dataIn),
        .returnDataValid (returnDataValid),
        .returnDataReady (returnDataReady),
        .returnData      (returnData),
        .evictDataValid  (evictDataValid),
        .evictDataReady  (evictDataReady),
        .evictData       (evictData),
        .refillDataValid (refillDataValid),
        .refillDataReady (refillDataReady),
        .refillData      (refillData),
        .storeDataValid  (storeDataValid),
        .storeDataReady  (storeDataReady),
        .storeData       (storeData),
        .loadDataValid   (loadDataValid),
        .loadDataReady   (loadDataReady),
        .loadData        (loadData)
    );

endmodule

/* tb/uoramDataPathTb.sv */
`timescale 1ns/1ns

module uoramDataPathTb;
    import uoramPkg::*;

    localparam int FedWidth      = 32;
    localparam int LeafWidth     = 64;
    localparam int BlockChunks   = 8;
    localparam int TimeoutCycles = 400;

    typedef logic [63:0] wordQ[$];

    logic                   Clock;
    logic                   rst;
    logic                   cmdValid;
    logic                   cmdReady;
    beCmdT                  cmd;
    logic [QDepthWidth-1:0] qDepth;
    logic                   dataInValid;
    logic                   dataInReady;
    logic [FedWidth-1:0]    dataIn;
    logic                   returnDataValid;
    logic                   returnDataReady;
    logic [FedWidth-1:0]    returnData;
    logic                   evictDataValid;
    logic                   evictDataReady;
    logic [LeafWidth-1:0]   evictData;
    logic                   refillDataValid;
    logic                   refillDataReady;
    logic [LeafWidth-1:0]   refillData;
    logic                   storeDataValid;
    logic                   storeDataReady;
    logic [FedWidth-1:0]    storeData;
    logic                   loadDataValid;
    logic                   loadDataReady;
    logic [FedWidth-1:0]    loadData;

    // per test, from the data file
    int   cmdQ[$];
    int   depthQ[$];
    wordQ netQ, loadQ, evQ, expStore, expReturn, expRefill;
    // collected output transfers
    wordQ gotStore, gotReturn, gotRefill;

    int          cntIn, cntRet, cntLoad;
    int          lastCmd, lastDepth, lastBase;
    int          testErrors, totalErrors, testsRun, testsFailed;
    logic        stallOn;
    logic        evictGo;
    logic [31:0] lfsr;

    uoramDataPath #(
        .FedWidth    (FedWidth),
        .LeafWidth   (LeafWidth),
        .BlockChunks (BlockChunks)
    ) i_dut (.*);

    initial begin
        Clock = 1'b0;
        forever #4 Clock = ~Clock;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // output readies, one lfsr step per bit
    always @(posedge Clock) begin
        #1;
        if (stallOn) begin
            lfsr = lfsrNext(lfsr);
            returnDataReady = lfsr[0];
            lfsr = lfsrNext(lfsr);
            refillDataReady = lfsr[0];
            lfsr = lfsrNext(lfsr);
            storeDataReady = lfsr[0];
        end else begin
            returnDataReady = 1'b1;
            refillDataReady = 1'b1;
            storeDataReady  = 1'b1;
        end
    end

    always @(posedge Clock) begin
        if (!rst) begin
            if (storeDataValid && storeDataReady) gotStore.push_back(64'(storeData));
            if (returnDataValid && returnDataReady) gotReturn.push_back(64'(returnData));
            if (refillDataValid && refillDataReady) gotRefill.push_back(refillData);
            if (dataInValid && dataInReady) cntIn <= cntIn + 1;
            if (returnDataValid && returnDataReady) cntRet <= cntRet + 1;
            if (loadDataValid && loadDataReady) cntLoad <= cntLoad + 1;
        end
    end

    // transfers so far on the stream that ends a flow of this kind
    function automatic int flowCount(input int c, input int d);
        if (d != 0) return cntLoad;
        if (c == int'(Read) || c == int'(ReadRmv)) return cntRet;
        return cntIn;
    endfunction

    function automatic logic readyOf(input int s);
        case (s)
            0: return cmdReady;
            1: return dataInReady;
            2: return loadDataReady;
            3: return evictDataReady;
            default: return evictGo;
        endcase
    endfunction

    function automatic string streamName(input int s);
        case (s)
            0: return "command";
            1: return "network in";
            2: return "backend load";
            3: return "PLB evict";
            default: return "evict start";
        endcase
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $finish;
    endtask

    // returns on the edge where the stream's ready is seen high
    task automatic waitReady(input int s);
        int cycles;
        cycles = 0;
        @(posedge Clock);
        while (!readyOf(s)) begin
            cycles++;
            if (cycles > TimeoutCycles) abortRun({"timeout: ", streamName(s), " stalled"});
            @(posedge Clock);
        end
    endtask

    task automatic readList(input int fd, output wordQ q);
        int          n;
        int          code;
        logic [63:0] v;
        q = {};
        code = $fscanf(fd, "%d", n);
        repeat (n) begin
            code = $fscanf(fd, "%h", v);
            q.push_back(v);
        end
    endtask

    task automatic compareStream(input string name, input wordQ got, input wordQ exp);
        int i;
        if (got.size() != exp.size()) begin
            $display("Error at %0t: %s transfers got %0d expected %0d",
                     $time, name, got.size(), exp.size());
            testErrors++;
        end
        for (i = 0; i < got.size() && i < exp.size(); i++) begin
            if (got[i] !== exp[i]) begin
                $display("Error at %0t: %s[%0d] got %h expected %h",
                         $time, name, i, got[i], exp[i]);
                testErrors++;
            end
        end
    endtask

    task automatic checkBlockDone();
        if (flowCount(lastCmd, lastDepth) - lastBase != BlockChunks) begin
            $display("Error at %0t: chunks moved in flow got %0d expected %0d",
                     $time, flowCount(lastCmd, lastDepth) - lastBase, BlockChunks);
            testErrors++;
        end
    endtask

    task automatic driveCommands();
        int i;
        for (i = 0; i < cmdQ.size(); i++) begin
            cmdValid = 1'b1;
            cmd      = beCmdT'(cmdQ[i]);
            qDepth   = QDepthWidth'(depthQ[i]);
            waitReady(0);
            // a second command must wait for the first block
            if (i > 0) checkBlockDone();
            lastCmd   = cmdQ[i];
            lastDepth = depthQ[i];
            lastBase  = flowCount(cmdQ[i], depthQ[i]);
            #1;
            if (depthQ[i] != 0) evictGo = 1'b1;
        end
        cmdValid = 1'b0;
    endtask

    task automatic runTest(input string name);
        int cycles;
        testErrors = 0;
        @(posedge Clock);
        #1;
        fork
            driveCommands();
            begin
                foreach (netQ[k]) begin
                    dataInValid = 1'b1;
                    dataIn      = netQ[k][FedWidth-1:0];
                    waitReady(1);
                    #1;
                end
                dataInValid = 1'b0;
            end
            begin
                foreach (loadQ[k]) begin
                    loadDataValid = 1'b1;
                    loadData      = loadQ[k][FedWidth-1:0];
                    waitReady(2);
                    #1;
                end
                loadDataValid = 1'b0;
            end
            begin
                // evicts start with the position-map access
                if (evQ.size() > 0) begin
                    waitReady(4);
                    #1;
                end
                foreach (evQ[k]) begin
                    evictDataValid = 1'b1;
                    evictData      = evQ[k];
                    waitReady(3);
                    #1;
                end
                evictDataValid = 1'b0;
            end
        join
        cycles = 0;
        @(posedge Clock);
        while (!cmdReady || storeDataValid || refillDataValid || returnDataValid) begin
            cycles++;
            if (cycles > TimeoutCycles) begin
                $display("timeout at end of flow: cmdReady=%b store=%b refill=%b return=%b",
                         cmdReady, storeDataValid, refillDataValid, returnDataValid);
                abortRun("output streams did not drain");
            end
            @(posedge Clock);
        end
        compareStream("storeData", gotStore, expStore);
        compareStream("returnData", gotReturn, expReturn);
        compareStream("refillData", gotRefill, expRefill);
        testsRun++;
        if (testErrors != 0) testsFailed++;
        totalErrors += testErrors;
        $display("test %-14s %s", name, (testErrors == 0) ? "passed" : "failed");
    endtask

    initial begin : mainSeq
        int               fd;
        int               code;
        int               c;
        int               d;
        int               stall;
        string            tag;
        string            name;
        logic [1023:0]    line;
        rst = 1'b1;
        cmdValid = 1'b0;
        cmd = Update;
        qDepth = '0;
        dataInValid = 1'b0;
        dataIn = '0;
        loadDataValid = 1'b0;
        loadData = '0;
        evictDataValid = 1'b0;
        evictData = '0;
        returnDataReady = 1'b1;
        refillDataReady = 1'b1;
        storeDataReady = 1'b1;
        stallOn = 1'b0;
        evictGo = 1'b0;
        lfsr = 32'hd4b6;
        cntIn = 0;
        cntRet = 0;
        cntLoad = 0;
        totalErrors = 0;
        testsRun = 0;
        testsFailed = 0;
        repeat (4) @(posedge Clock);
        #1;
        rst = 1'b0;

        // reset state
        testErrors = 0;
        @(posedge Clock);
        if (cmdReady !== 1'b1) begin
            $display("Error at %0t: cmdReady got %b expected 1", $time, cmdReady);
            testErrors++;
        end
        if ({storeDataValid, returnDataValid, refillDataValid} !== 3'b000) begin
            $display("Error at %0t: store/return/refill valid got %b expected 000",
                     $time, {storeDataValid, returnDataValid, refillDataValid});
            testErrors++;
        end
        testsRun++;
        if (testErrors != 0) testsFailed++;
        totalErrors += testErrors;
        $display("test %-14s %s", "reset", (testErrors == 0) ? "passed" : "failed");

        fd = $fopen("tb/uoramDataPathStim.txt", "r");
        if (fd == 0) abortRun("cannot open tb/uoramDataPathStim.txt");
        while ($fscanf(fd, "%s", tag) == 1) begin
            case (tag)
                "#": code = $fgets(line, fd);
                "T": begin
                    code = $fscanf(fd, "%s %d", name, stall);
                    stallOn = (stall != 0);
                    evictGo = 1'b0;
                    cmdQ = {};
                    depthQ = {};
                    netQ = {};
                    loadQ = {};
                    evQ = {};
                    expStore = {};
                    expReturn = {};
                    expRefill = {};
                    gotStore = {};
                    gotReturn = {};
                    gotRefill = {};
                end
                "C": begin
                    code = $fscanf(fd, "%d %d", c, d);
                    cmdQ.push_back(c);
                    depthQ.push_back(d);
                end
                "N": readList(fd, netQ);
                "L": readList(fd, loadQ);
                "E": readList(fd, evQ);
                "S": readList(fd, expStore);
                "R": readList(fd, expReturn);
                "F": readList(fd, expRefill);
                "G": runTest(name);
                default: abortRun({"unknown record in stimulus file: ", tag});
            endcase
        end
        $fclose(fd);

        $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, totalErrors);
        if (totalErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* tb/uoramDataPathStim.txt */
# T name stall, C cmd depth, then N net L load E evict S store R return F refill: count, hex
# cmd 0 Update 1 Append 2 Read 3 ReadRmv, stall 1 stalls outputs at random, G runs the test
T update 0
C 0 0
N 8 a0000000 a0000001 a0000002 a0000003 a0000004 a0000005 a0000006 a0000007
S 8 a0000000 a0000001 a0000002 a0000003 a0000004 a0000005 a0000006 a0000007
G
T appendStall 1
C 1 0
N 8 a1000000 a1000001 a1000002 a1000003 a1000004 a1000005 a1000006 a1000007
S 8 a1000000 a1000001 a1000002 a1000003 a1000004 a1000005 a1000006 a1000007
G
T read 0
C 2 0
L 8 b0000000 b0000001 b0000002 b0000003 b0000004 b0000005 b0000006 b0000007
R 8 b0000000 b0000001 b0000002 b0000003 b0000004 b0000005 b0000006 b0000007
G
T readRmvStall 1
C 3 0
L 8 b1000000 b1000001 b1000002 b1000003 b1000004 b1000005 b1000006 b1000007
R 8 b1000000 b1000001 b1000002 b1000003 b1000004 b1000005 b1000006 b1000007
G
T posMap 0
C 2 3
L 8 10000000 10000001 10000002 10000003 10000004 10000005 10000006 10000007
F 4 1000000110000000 1000000310000002 1000000510000004 1000000710000006
E 4 c0000001c0000000 c0000003c0000002 c0000005c0000004 c0000007c0000006
S 8 c0000000 c0000001 c0000002 c0000003 c0000004 c0000005 c0000006 c0000007
G
T posMapStall 1
C 0 15
L 8 20000000 20000001 20000002 20000003 20000004 20000005 20000006 20000007
F 4 2000000120000000 2000000320000002 2000000520000004 2000000720000006
E 2 d0000001d0000000 d0000003d0000002
S 4 d0000000 d0000001 d0000002 d0000003
G
T holdStoreRead 1
C 0 0
C 2 0
N 8 e0000000 e0000001 e0000002 e0000003 e0000004 e0000005 e0000006 e0000007
L 8 e1000000 e1000001 e1000002 e1000003 e1000004 e1000005 e1000006 e1000007
S 8 e0000000 e0000001 e0000002 e0000003 e0000004 e0000005 e0000006 e0000007
R 8 e1000000 e1000001 e1000002 e1000003 e1000004 e1000005 e1000006 e1000007
G
T holdReadPosMap 1
C 3 0
C 0 4
L 16 f0000000 f0000001 f0000002 f0000003 f0000004 f0000005 f0000006 f0000007
f0000008 f0000009 f000000a f000000b f000000c f000000d f000000e f000000f
R 8 f0000000 f0000001 f0000002 f0000003 f0000004 f0000005 f0000006 f0000007
F 4 f0000009f0000008 f000000bf000000a f000000df000000c f000000ff000000e
E 2 f1000001f1000000 f1000003f1000002
S 4 f1000000 f1000001 f1000002 f1000003
G

/* uoramDataPath.f */
design/uoramPkg.sv
design/routeCtrlIf.sv
design/storeBuffer.sv
design/refillFunnel.sv
design/evictFunnel.sv
design/chunkRouter.sv
design/accessSequencer.sv
design/uoramDataPath.sv
tb/uoramDataPathTb.sv

/* Bender.yml */
package:
  name: uoram_data_path

sources:
  - files:
      - design/uoramPkg.sv
      - design/routeCtrlIf.sv
      - design/storeBuffer.sv
      - design/refillFunnel.sv
      - design/evictFunnel.sv
      - design/chunkRouter.sv
      - design/accessSequencer.sv
      - design/uoramDataPath.sv
  - target: test
    files:
      - tb/uoramDataPathTb.sv
